// File: design/bp_pkg.sv
/*
 * branch-resolution slice, shared definitions
 * instruction format, opcode codes, predictor states and statistics width
 */

`default_nettype none

package bp_pkg;

   // instruction format: [15:12] opcode, [11:6] operand a, [5:0] operand b
   localparam int INSN_W = 16;
   localparam int OPC_W  = 4;
   localparam int OPND_W = 6;

   typedef logic [INSN_W-1:0] insn_t;    // raw instruction word
   typedef logic [OPC_W-1:0]  opcode_t;  // opcode field
   typedef logic [OPND_W-1:0] operand_t; // compare immediate

   // field positions inside insn_t
   localparam int OPC_MSB = INSN_W - 1;
   localparam int A_MSB   = 2*OPND_W - 1;
   localparam int B_MSB   = OPND_W - 1;

   // opcodes, anything else decodes as nop
   localparam opcode_t OP_SFEQ  = 4'd1;  // flag = a == b
   localparam opcode_t OP_SFNE  = 4'd2;  // flag = a != b
   localparam opcode_t OP_SFLTU = 4'd3;  // flag = a < b, unsigned
   localparam opcode_t OP_BF    = 4'd4;  // branch if flag
   localparam opcode_t OP_BNF   = 4'd5;  // branch if no flag

   // branch and mispredict statistics
   localparam int CNT_W = 16;
   typedef logic [CNT_W-1:0] count_t;
   localparam count_t CNT_MAX = '1;      // saturation point

   // two-bit saturating counter states
   typedef enum logic [1:0] {
      ST_STRONG_NT = 2'd0,
      ST_WEAK_NT   = 2'd1,
      ST_WEAK_T    = 2'd2,
      ST_STRONG_T  = 2'd3
   } bp_state_t;

   localparam bp_state_t BP_RESET_STATE = ST_WEAK_T; // start weakly taken

endpackage

`default_nettype wire

// File: design/bp_decode.sv
/*
 * decode stage
 * registers the instruction strobe and splits the word into
 * compare / bf / bnf class flags plus operands
 */

`timescale 1ns/1ps
`default_nettype none

module bp_decode (
   input  wire                clk,
   input  wire                rst,
   input  wire                insn_valid_i,
   input  bp_pkg::insn_t      insn_i,
   output logic               dec_valid_o,
   output logic               dec_sf_o,      // compare op
   output logic               dec_bf_o,
   output logic               dec_bnf_o,
   output bp_pkg::opcode_t    dec_cmp_op_o,
   output bp_pkg::operand_t   dec_a_o,
   output bp_pkg::operand_t   dec_b_o
);

   import bp_pkg::*;

   opcode_t  opc;
   operand_t opnd_a;
   operand_t opnd_b;
   logic     is_sf;
   logic     is_bf;
   logic     is_bnf;

   // field split
   assign opc    = insn_i[OPC_MSB -: OPC_W];
   assign opnd_a = insn_i[A_MSB -: OPND_W];
   assign opnd_b = insn_i[B_MSB -: OPND_W];

   // classify, all gated by the strobe
   assign is_sf  = insn_valid_i &&
                   ((opc == OP_SFEQ) || (opc == OP_SFNE) || (opc == OP_SFLTU));
   assign is_bf  = insn_valid_i && (opc == OP_BF);
   assign is_bnf = insn_valid_i && (opc == OP_BNF);

   // control flags
   always_ff @(posedge clk) begin
      if (rst) begin
         dec_valid_o <= 1'b0;
         dec_sf_o    <= 1'b0;
         dec_bf_o    <= 1'b0;
         dec_bnf_o   <= 1'b0;
      end else begin
         dec_valid_o <= insn_valid_i;
         dec_sf_o    <= is_sf;
         dec_bf_o    <= is_bf;
         dec_bnf_o   <= is_bnf;
      end
   end

   // payload, only looked at when a class flag is set
   always_ff @(posedge clk) begin
      dec_cmp_op_o <= opc;
      dec_a_o      <= opnd_a;
      dec_b_o      <= opnd_b;
   end

endmodule

`default_nettype wire

// File: design/bp_sat_predictor.sv
/*
 * two-bit saturating counter branch predictor
 * predicts the flag for the branch in decode, steps on each resolution
 * from execute; a same-cycle resolution is bypassed into the prediction
 */

`timescale 1ns/1ps
`default_nettype none

module bp_sat_predictor (
   input  wire   clk,
   input  wire   rst,
   input  wire   dec_valid_i,
   input  wire   op_bf_i,      // decode holds bf
   input  wire   op_bnf_i,     // decode holds bnf
   input  wire   resolve_i,    // branch resolving in execute
   input  wire   taken_i,      // its real direction
   output logic  pred_flag_o
);

   import bp_pkg::*;

   bp_state_t state_q;
   bp_state_t state_nxt;
   logic      pred_taken;

   // saturating step on resolution
   always_comb begin
      state_nxt = state_q;
      if (resolve_i) begin
         if (taken_i) begin
            case (state_q)
               ST_STRONG_NT: state_nxt = ST_WEAK_NT;
               ST_WEAK_NT:   state_nxt = ST_WEAK_T;
               default:      state_nxt = ST_STRONG_T;   // saturate high
            endcase
         end else begin
            case (state_q)
               ST_STRONG_T:  state_nxt = ST_WEAK_T;
               ST_WEAK_T:    state_nxt = ST_WEAK_NT;
               default:      state_nxt = ST_STRONG_NT;  // saturate low
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) state_q <= BP_RESET_STATE;
      else     state_q <= state_nxt;
   end

   // predict from the next state so an older branch resolving now counts
   assign pred_taken = (state_nxt == ST_WEAK_T) || (state_nxt == ST_STRONG_T);

   // bf expects flag set when taken, bnf expects flag set when not taken
   assign pred_flag_o = dec_valid_i &&
                        ((op_bf_i && pred_taken) || (op_bnf_i && !pred_taken));

endmodule

`default_nettype wire

// File: design/bp_execute.sv
/*
 * execute stage
 * evaluates set-flag compares into the architectural flag, resolves
 * conditional branches and flags mispredictions
 */

`timescale 1ns/1ps
`default_nettype none

module bp_execute (
   input  wire                clk,
   input  wire                rst,
   input  wire                dec_valid_i,
   input  wire                dec_sf_i,
   input  wire                dec_bf_i,
   input  wire                dec_bnf_i,
   input  wire                pred_flag_i,
   input  bp_pkg::opcode_t    dec_cmp_op_i,
   input  bp_pkg::operand_t   dec_a_i,
   input  bp_pkg::operand_t   dec_b_i,
   output logic               res_brcond_o,   // branch held this cycle
   output logic               res_taken_o,
   output logic               ex_valid_o,
   output logic               ex_is_branch_o,
   output logic               ex_flag_o,      // flag after this insn
   output logic               ex_pred_flag_o,
   output logic               ex_mispredict_o
);

   import bp_pkg::*;

   logic flag_q;       // architectural flag
   logic flag_nxt;
   logic bf_q;
   logic bnf_q;
   logic is_branch;

   assign is_branch = dec_bf_i || dec_bnf_i;

   // compare evaluation, flag holds for anything else
   always_comb begin
      flag_nxt = flag_q;
      if (dec_sf_i) begin
         case (dec_cmp_op_i)
            OP_SFEQ:  flag_nxt = (dec_a_i == dec_b_i);
            OP_SFNE:  flag_nxt = (dec_a_i != dec_b_i);
            OP_SFLTU: flag_nxt = (dec_a_i <  dec_b_i);  // unsigned
            default:  flag_nxt = flag_q;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         flag_q          <= 1'b0;
         ex_valid_o      <= 1'b0;
         bf_q            <= 1'b0;
         bnf_q           <= 1'b0;
         ex_pred_flag_o  <= 1'b0;
         ex_mispredict_o <= 1'b0;
      end else begin
         flag_q          <= flag_nxt;
         ex_valid_o      <= dec_valid_i;
         bf_q            <= dec_bf_i;
         bnf_q           <= dec_bnf_i;
         ex_pred_flag_o  <= is_branch && pred_flag_i;
         // branch leaves the flag alone, so flag_q is what it tests
         ex_mispredict_o <= is_branch && (pred_flag_i != flag_q);
      end
   end

   assign ex_flag_o      = flag_q;
   assign ex_is_branch_o = bf_q || bnf_q;

   // resolution back to the predictor
   assign res_brcond_o = bf_q || bnf_q;
   assign res_taken_o  = (bf_q && flag_q) || (bnf_q && !flag_q);

endmodule

`default_nettype wire

// File: design/bp_result.sv
/*
 * result stage
 * registered retire report plus saturating branch and
 * misprediction counters
 */

`timescale 1ns/1ps
`default_nettype none

module bp_result (
   input  wire              clk,
   input  wire              rst,
   input  wire              ex_valid_i,
   input  wire              ex_is_branch_i,
   input  wire              ex_flag_i,
   input  wire              ex_pred_flag_i,
   input  wire              ex_mispredict_i,
   output logic             out_valid_o,
   output logic             out_is_branch_o,
   output logic             out_flag_o,
   output logic             out_pred_flag_o,
   output logic             out_mispredict_o,
   output bp_pkg::count_t   branch_count_o,
   output bp_pkg::count_t   mispredict_count_o
);

   import bp_pkg::*;

   logic br_inc;   // retiring a branch
   logic mp_inc;   // retiring a mispredicted branch

   assign br_inc = ex_valid_i && ex_is_branch_i;
   assign mp_inc = br_inc && ex_mispredict_i;

   // report control bits
   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid_o      <= 1'b0;
         out_is_branch_o  <= 1'b0;
         out_mispredict_o <= 1'b0;
      end else begin
         out_valid_o      <= ex_valid_i;
         out_is_branch_o  <= br_inc;
         out_mispredict_o <= mp_inc;
      end
   end

   // report payload
   always_ff @(posedge clk) begin
      out_flag_o      <= ex_flag_i;
      out_pred_flag_o <= ex_pred_flag_i;
   end

   // counters move on the same edge as out_valid_o
   always_ff @(posedge clk) begin
      if (rst) begin
         branch_count_o     <= '0;
         mispredict_count_o <= '0;
      end else begin
         if (br_inc && (branch_count_o != CNT_MAX))
            branch_count_o <= branch_count_o + count_t'(1);
         if (mp_inc && (mispredict_count_o != CNT_MAX))
            mispredict_count_o <= mispredict_count_o + count_t'(1);   // sticks at max
      end
   end

endmodule

`default_nettype wire

// File: design/bp_top.sv
/*
 * branch-resolution slice top
 * decode and predictor side by side, then execute and result;
 * fixed three-cycle latency from strobe to retire report
 */

`timescale 1ns/1ps
`default_nettype none

module bp_top (
   input  wire              clk,
   input  wire              rst,
   input  wire              insn_valid_i,
   input  bp_pkg::insn_t    insn_i,
   output logic             out_valid_o,
   output logic             out_is_branch_o,
   output logic             out_flag_o,
   output logic             out_pred_flag_o,
   output logic             out_mispredict_o,
   output bp_pkg::count_t   branch_count_o,
   output bp_pkg::count_t   mispredict_count_o
);

   import bp_pkg::*;

   // decode -> execute / predictor
   logic     dec_valid;
   logic     dec_sf;
   logic     dec_bf;
   logic     dec_bnf;
   opcode_t  dec_cmp_op;
   operand_t dec_a;
   operand_t dec_b;

   // predictor <-> execute
   logic pred_flag;
   logic res_brcond;
   logic res_taken;

   // execute -> result
   logic ex_valid;
   logic ex_is_branch;
   logic ex_flag;
   logic ex_pred_flag;
   logic ex_mispredict;

   bp_decode u_decode (
      .clk          (clk),
      .rst          (rst),
      .insn_valid_i (insn_valid_i),
      .insn_i       (insn_i),
      .dec_valid_o  (dec_valid),
      .dec_sf_o     (dec_sf),
      .dec_bf_o     (dec_bf),
      .dec_bnf_o    (dec_bnf),
      .dec_cmp_op_o (dec_cmp_op),
      .dec_a_o      (dec_a),
      .dec_b_o      (dec_b)
   );

   bp_sat_predictor u_predictor (
      .clk         (clk),
      .rst         (rst),
      .dec_valid_i (dec_valid),
      .op_bf_i     (dec_bf),
      .op_bnf_i    (dec_bnf),
      .resolve_i   (res_brcond),
      .taken_i     (res_taken),
      .pred_flag_o (pred_flag)
   );

   bp_execute u_execute (
      .clk             (clk),
      .rst             (rst),
      .dec_valid_i     (dec_valid),
      .dec_sf_i        (dec_sf),
      .dec_bf_i        (dec_bf),
      .dec_bnf_i       (dec_bnf),
      .pred_flag_i     (pred_flag),
      .dec_cmp_op_i    (dec_cmp_op),
      .dec_a_i         (dec_a),
      .dec_b_i         (dec_b),
      .res_brcond_o    (res_brcond),
      .res_taken_o     (res_taken),
      .ex_valid_o      (ex_valid),
      .ex_is_branch_o  (ex_is_branch),
      .ex_flag_o       (ex_flag),
      .ex_pred_flag_o  (ex_pred_flag),
      .ex_mispredict_o (ex_mispredict)
   );

   bp_result u_result (
      .clk                (clk),
      .rst                (rst),
      .ex_valid_i         (ex_valid),
      .ex_is_branch_i     (ex_is_branch),
      .ex_flag_i          (ex_flag),
      .ex_pred_flag_i     (ex_pred_flag),
      .ex_mispredict_i    (ex_mispredict),
      .out_valid_o        (out_valid_o),
      .out_is_branch_o    (out_is_branch_o),
      .out_flag_o         (out_flag_o),
      .out_pred_flag_o    (out_pred_flag_o),
      .out_mispredict_o   (out_mispredict_o),
      .branch_count_o     (branch_count_o),
      .mispredict_count_o (mispredict_count_o)
   );

endmodule

`default_nettype wire

// File: bench/bp_tb.sv
/*
 * testbench for the branch-resolution slice
 * directed flag and predictor runs, back-to-back branches and a random
 * stream, all checked against a sequential reference model
 */

`timescale 1ns/1ps
`default_nettype none

module bp_tb;

   import bp_pkg::*;

   localparam int SEED     = 74502;
   localparam int N_RANDOM = 2000;
   localparam int N_DIRECT = 31;                          // flag + predictor + bypass runs
   localparam int LIMIT    = 2*(N_RANDOM + N_DIRECT) + 100;

   typedef struct packed {
      logic   is_branch;
      logic   flag;
      logic   pred_flag;
      logic   mispredict;
      count_t br_cnt;
      count_t mp_cnt;
   } report_t;

   logic   clk;
   logic   rst;
   logic   insn_valid;
   insn_t  insn;
   logic   out_valid;
   logic   out_is_branch;
   logic   out_flag;
   logic   out_pred_flag;
   logic   out_mispredict;
   count_t branch_count;
   count_t mispredict_count;

   // reference model state, one instruction at a time
   logic      m_flag   = 1'b0;
   bp_state_t m_state  = ST_WEAK_T;
   count_t    m_br_cnt = '0;
   count_t    m_mp_cnt = '0;

   report_t exp_q[$];     // expected reports, issue order
   int      issue_q[$];   // issue cycle per instruction
   int      cycle     = 0;

   bp_top i_dut (
      .clk                (clk),
      .rst                (rst),
      .insn_valid_i       (insn_valid),
      .insn_i             (insn),
      .out_valid_o        (out_valid),
      .out_is_branch_o    (out_is_branch),
      .out_flag_o         (out_flag),
      .out_pred_flag_o    (out_pred_flag),
      .out_mispredict_o   (out_mispredict),
      .branch_count_o     (branch_count),
      .mispredict_count_o (mispredict_count)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;   // 20 ns period
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display(">>> FAIL");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp)
         abort_run($sformatf("CHECK FAILED @ %0t: %s is %b, expected %b", $time, what, got, exp));
   endtask

   task automatic check_count(input count_t got, input count_t exp, input string what);
      if (got !== exp)
         abort_run($sformatf("CHECK FAILED @ %0t: %s is %0d, expected %0d", $time, what, got, exp));
   endtask

   task automatic check_report(input report_t got, input report_t exp);
      check_bit(got.is_branch, exp.is_branch, "out_is_branch");
      check_bit(got.flag, exp.flag, "out_flag");
      check_bit(got.pred_flag, exp.pred_flag, "out_pred_flag");
      check_bit(got.mispredict, exp.mispredict, "out_mispredict");
      check_count(got.br_cnt, exp.br_cnt, "branch_count");
      check_count(got.mp_cnt, exp.mp_cnt, "mispredict_count");
   endtask

   // sequential model: flag, 2-bit counter, both counts
   function automatic report_t ref_step(input insn_t w);
      report_t  r;
      opcode_t  opc;
      operand_t a;
      operand_t b;
      logic     pred_t;    // counter in a taken state
      logic     taken;
      opc    = w[15:12];
      a      = w[11:6];
      b      = w[5:0];
      r      = '0;
      pred_t = (m_state == ST_WEAK_T) || (m_state == ST_STRONG_T);
      case (opc)
         OP_SFEQ:  m_flag = (a == b);
         OP_SFNE:  m_flag = (a != b);
         OP_SFLTU: m_flag = (a < b);
         OP_BF, OP_BNF: begin
            r.is_branch  = 1'b1;
            r.pred_flag  = (opc == OP_BF) ? pred_t : !pred_t;
            r.mispredict = (r.pred_flag != m_flag);
            taken        = (opc == OP_BF) ? m_flag : !m_flag;
            if (taken && (m_state != ST_STRONG_T))
               m_state = bp_state_t'(m_state + 2'd1);
            else if (!taken && (m_state != ST_STRONG_NT))
               m_state = bp_state_t'(m_state - 2'd1);
            if (m_br_cnt != '1) m_br_cnt = m_br_cnt + count_t'(1);   // saturating
            if (r.mispredict && (m_mp_cnt != '1)) m_mp_cnt = m_mp_cnt + count_t'(1);
         end
         default: ;   // nop keeps the flag
      endcase
      r.flag   = m_flag;
      r.br_cnt = m_br_cnt;
      r.mp_cnt = m_mp_cnt;
      return r;
   endfunction

   function automatic insn_t make_insn(input opcode_t opc, input operand_t a, input operand_t b);
      return {opc, a, b};
   endfunction

   // about 40% branches, 40% compares, rest nops
   function automatic insn_t random_insn();
      int unsigned pick;
      int unsigned r;
      opcode_t     opc;
      operand_t    a;
      operand_t    b;
      pick = $urandom_range(99, 0);
      r    = $urandom;
      a    = r[5:0];
      b    = r[12] ? a : r[11:6];   // equal operands half the time
      opc  = r[17:14];
      if (pick < 40) opc = r[13] ? OP_BF : OP_BNF;
      else if (pick < 80) opc = opcode_t'(1 + $urandom_range(2, 0));
      else if ((opc >= 4'd1) && (opc <= 4'd5)) opc = opc + 4'd5;   // move into nop space
      return make_insn(opc, a, b);
   endfunction

   task automatic send_insn(input insn_t w);
      @(posedge clk);
      insn_valid <= 1'b1;
      insn       <= w;
      exp_q.push_back(ref_step(w));
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         insn_valid <= 1'b0;
      end
   endtask

   task automatic wait_for_drain();
      idle_cycles(1);
      while (exp_q.size() != 0) @(negedge clk);
   endtask

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= LIMIT)
         abort_run($sformatf("timeout: run still going after %0d cycles", cycle));
   end

   // compare process, outputs settled at the falling edge
   always @(negedge clk) begin : compare_outputs
      report_t e;
      int      lat;
      if (!rst && insn_valid) issue_q.push_back(cycle);
      if (!rst && out_valid) begin
         if (exp_q.size() == 0) begin
            abort_run("output strobe seen with no instruction in flight");
         end else begin
            e   = exp_q.pop_front();
            lat = cycle - issue_q.pop_front();
            if (lat != 3)
               abort_run($sformatf("CHECK FAILED @ %0t: latency %0d cycles, expected 3", $time, lat));
            check_report({out_is_branch, out_flag, out_pred_flag, out_mispredict,
                          branch_count, mispredict_count}, e);
         end
      end
   end

   initial begin
      void'($urandom(SEED));
      rst        = 1'b1;
      insn_valid = 1'b0;
      insn       = '0;
      repeat (16) @(posedge clk);
      rst <= 1'b0;

      // idle after reset
      repeat (6) begin
         @(negedge clk);
         check_bit(out_valid, 1'b0, "out_valid while idle");
         check_count(branch_count, count_t'(0), "branch_count while idle");
         check_count(mispredict_count, count_t'(0), "mispredict_count while idle");
      end

      // flag set and clear by compares, nops hold it
      send_insn(make_insn(OP_SFEQ, 6'd5, 6'd5));
      send_insn(make_insn(4'd0, 6'd1, 6'd2));
      send_insn(make_insn(OP_SFNE, 6'd9, 6'd9));
      send_insn(make_insn(OP_SFLTU, 6'd3, 6'd7));
      send_insn(make_insn(OP_SFLTU, 6'd7, 6'd3));
      send_insn(make_insn(OP_SFNE, 6'd1, 6'd2));
      send_insn(make_insn(4'd15, 6'd0, 6'd0));
      send_insn(make_insn(OP_SFEQ, 6'd4, 6'd5));
      send_insn(make_insn(OP_SFLTU, 6'd63, 6'd0));
      send_insn(make_insn(OP_SFLTU, 6'd0, 6'd63));
      wait_for_drain();
      check_bit(out_flag, 1'b1, "flag after compare run");

      // weak taken -> strong, then down to strong not taken and back
      send_insn(make_insn(OP_SFEQ, 6'd5, 6'd5));
      repeat (3) send_insn(make_insn(OP_BF, 6'd0, 6'd0));   // taken, last one saturates
      send_insn(make_insn(OP_SFNE, 6'd5, 6'd5));
      repeat (4) send_insn(make_insn(OP_BF, 6'd0, 6'd0));   // first two mispredicted
      send_insn(make_insn(OP_SFLTU, 6'd1, 6'd2));
      send_insn(make_insn(OP_BF, 6'd0, 6'd0));              // taken from strong nt
      wait_for_drain();
      check_count(branch_count, count_t'(8), "branches after predictor run");
      check_count(mispredict_count, count_t'(3), "mispredicts after predictor run");

      // back-to-back branches through the bypass
      send_insn(make_insn(OP_SFEQ, 6'd3, 6'd3));
      send_insn(make_insn(OP_BF, 6'd0, 6'd0));
      send_insn(make_insn(OP_BNF, 6'd0, 6'd0));
      send_insn(make_insn(OP_BF, 6'd0, 6'd0));
      send_insn(make_insn(OP_SFNE, 6'd2, 6'd2));
      send_insn(make_insn(OP_BNF, 6'd0, 6'd0));
      send_insn(make_insn(OP_BNF, 6'd0, 6'd0));
      send_insn(make_insn(OP_BF, 6'd0, 6'd0));
      send_insn(make_insn(OP_BF, 6'd0, 6'd0));
      send_insn(make_insn(OP_BNF, 6'd0, 6'd0));
      wait_for_drain();

      // random stream with short gaps
      for (int i = 0; i < N_RANDOM; i++) begin
         send_insn(random_insn());
         if ($urandom_range(3, 0) == 0) idle_cycles(1 + $urandom_range(1, 0));
      end
      wait_for_drain();

      // quiet tail, a late strobe or a stray count step shows up here
      idle_cycles(4);
      @(negedge clk);
      check_count(branch_count, m_br_cnt, "branch_count after quiet tail");
      check_count(mispredict_count, m_mp_cnt, "mispredict_count after quiet tail");
      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog.f
design/bp_pkg.sv
design/bp_decode.sv
design/bp_sat_predictor.sv
design/bp_execute.sv
design/bp_result.sv
design/bp_top.sv
bench/bp_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the branch slice testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module bp_tb -f verilog.f \
   || { echo "verilator build failed"; exit 1; }
out=$(./obj_dir/Vbp_tb 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx '>>> PASS' && exit 0 || exit 1
